// ==== Bender.yml ====
package:
  name: obj_layer

sources:
  - verilog/obj_pkg.sv
  - verilog/obj_ram.sv
  - verilog/obj_scan.sv
  - verilog/obj_draw.sv
  - verilog/obj_line_buffer.sv
  - verilog/obj_layer.sv
  - target: test
    files:
      - testbench/obj_rom_model.sv
      - testbench/obj_layer_tb.sv

// ==== list.f ====
verilog/obj_pkg.sv
verilog/obj_ram.sv
verilog/obj_scan.sv
verilog/obj_draw.sv
verilog/obj_line_buffer.sv
verilog/obj_layer.sv
testbench/obj_rom_model.sv
testbench/obj_layer_tb.sv

// ==== testbench/obj_layer_tb.sv ====
/*
 * Object layer testbench
 * Runs video lines against the sprite layer, writes object tables during
 * blanking and checks every output pixel against a reference line built
 * from the testbench copy of the table.
 */

`timescale 1ns/10ps

module obj_layer_tb;

    import obj_pkg::*;

    localparam int max_line_objs = 32;
    localparam int obj_count     = 102;
    localparam int total_lines   = 4 + 24 + 37 + 5 + 5 + 12 + 3 * 40;
    localparam int timeout_clk   = total_lines * 4400 + 2000;

    logic      clk, rst, obj_cs, cpu_wrn, hbl, pxl_cen, rom_ok;
    ram_addr_t cpu_addr;
    byte_t     cpu_dout, obj_dout, vpos;
    rom_addr_t rom_addr;
    rom_word_t rom_data;
    pxl_t      obj_pxl;

    integer    seed = 32'h664841ca;
    byte_t     tb_ram [0:511];         // copy of the object table
    pxl_t      exp_cur [0:255];        // line now on screen
    pxl_t      exp_next [0:255];       // line being drawn
    logic      cur_valid, next_valid;
    byte_t     cur_vpos, shown_vpos, drawn_vpos;
    ram_addr_t wr_addr_q [$];
    byte_t     wr_data_q [$];
    logic [1:0] cen_pipe = '0;
    logic [8:0] pix_idx  = '0;
    int        n_checked = 0;
    int        cycles    = 0;

    obj_layer #(
        .max_line_objs (max_line_objs),
        .obj_count     (obj_count)
    ) i_obj_layer (
        .clk      (clk),
        .rst      (rst),
        .obj_cs   (obj_cs),
        .cpu_wrn  (cpu_wrn),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .obj_dout (obj_dout),
        .vpos     (vpos),
        .hbl      (hbl),
        .pxl_cen  (pxl_cen),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .obj_pxl  (obj_pxl)
    );

    obj_rom_model i_obj_rom_model (
        .clk      (clk),
        .rst      (rst),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok)
    );

    always #10 clk = ~clk;

    task automatic abort_run;
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    // same hash as the ROM model
    function automatic rom_word_t rom_hash(input rom_addr_t a);
        logic [31:0] h;
        h = {14'd0, a} * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h85ebca6b;
        h = h ^ (h >> 13);
        return h[31:16] & h[15:0];
    endfunction

    // reference line, table order, later objects on top
    function automatic void expected_line(input byte_t v);
        byte_t      y, attr, attr2, tile, x;
        logic [8:0] s, pos;
        logic [3:0] pi, col;
        rom_word_t  w;
        int         i, p, k, drawn;
        for (p = 0; p < 256; p++) exp_next[p] = '0;
        drawn = 0;
        for (i = 0; i < obj_count && drawn < max_line_objs; i++) begin
            y     = tb_ram[5 * i];
            attr  = tb_ram[5 * i + 1];
            attr2 = tb_ram[5 * i + 2];
            tile  = tb_ram[5 * i + 3];
            x     = tb_ram[5 * i + 4];
            s     = {1'b0, v} + {1'b0, y};
            if (attr[7] && s[7:5] == 3'b111 && s[8] == attr[0] && (s[4] || attr[4])) begin
                drawn++;
                for (p = 0; p < 16; p++) begin
                    pi  = 4'(p);
                    k   = p % 4;
                    w   = rom_hash({attr2[3:0], tile, s[3:0], pi[3:2]});
                    col = {w[12 + k], w[8 + k], w[4 + k], w[k]};
                    pos = {1'b0, x} + (attr[3] ? 9'(15 - p) : 9'(p));  // mirrored row
                    if (col != 4'd0 && !pos[8]) exp_next[pos[7:0]] = {attr2[7:4], col};
                end
            end
        end
    endfunction

    // write one byte, read it back and keep the table copy
    task automatic cpu_write(input ram_addr_t a, input byte_t d);
        @(posedge clk);
        obj_cs   <= 1'b1;
        cpu_wrn  <= 1'b0;
        cpu_addr <= a;
        cpu_dout <= d;
        @(posedge clk);
        cpu_wrn <= 1'b1;
        @(posedge clk);
        obj_cs <= 1'b0;
        @(negedge clk);
        assert (obj_dout === d) else begin
            $display("** Error at %0t: obj_dout at address %h is %h, expected %h",
                     $time, a, obj_dout, d);
            abort_run();
        end
        tb_ram[a] = d;
    endtask

    task automatic queue_byte(input ram_addr_t a, input byte_t d);
        wr_addr_q.push_back(a);
        wr_data_q.push_back(d);
    endtask

    task automatic queue_obj(input int idx, input byte_t y, input byte_t attr,
                             input byte_t attr2, input byte_t tile, input byte_t x);
        queue_byte(ram_addr_t'(5 * idx), y);
        queue_byte(ram_addr_t'(5 * idx + 1), attr);
        queue_byte(ram_addr_t'(5 * idx + 2), attr2);
        queue_byte(ram_addr_t'(5 * idx + 3), tile);
        queue_byte(ram_addr_t'(5 * idx + 4), x);
    endtask

    task automatic queue_random_table;
        byte_t d;
        int    a;
        for (a = 0; a < 5 * obj_count; a++) begin
            d = byte_t'($random(seed));
            if (a % 5 == 1) d[7] = 1'b1;  // every object enabled
            queue_byte(ram_addr_t'(a), d);
        end
    endtask

    // blank with up to 90 cpu writes, then 256 pixels
    task automatic run_lines(input int n);
        int        nw, p;
        ram_addr_t a;
        byte_t     d;
        repeat (n) begin
            @(posedge clk);
            hbl  <= 1'b1;
            vpos <= cur_vpos;
            nw = 0;
            while (wr_addr_q.size() > 0 && nw < 90) begin
                a = wr_addr_q.pop_front();
                d = wr_data_q.pop_front();
                cpu_write(a, d);
                nw++;
            end
            repeat (300 - 3 * nw) @(posedge clk);
            hbl <= 1'b0;
            for (p = 0; p < 256; p++) exp_cur[p] = exp_next[p];
            cur_valid  = next_valid;
            shown_vpos = drawn_vpos;
            drawn_vpos = cur_vpos;
            expected_line(cur_vpos);
            next_valid = 1'b1;
            cur_vpos++;
            repeat (256) begin
                repeat (15) @(posedge clk);
                pxl_cen <= 1'b1;
                @(posedge clk);
                pxl_cen <= 1'b0;
            end
        end
    endtask

    // obj_pxl settles two clk after each strobe
    always @(posedge clk) begin
        cen_pipe <= {cen_pipe[0], pxl_cen};
        if (cen_pipe[1]) begin
            if (cur_valid) begin
                assert (obj_pxl === exp_cur[pix_idx[7:0]]) else begin
                    $display("** Error at %0t: obj_pxl at x=%0d (vpos %0d) is %h, expected %h",
                             $time, pix_idx, shown_vpos, obj_pxl, exp_cur[pix_idx[7:0]]);
                    abort_run();
                end
                n_checked <= n_checked + 1;
            end
            pix_idx <= pix_idx + 9'd1;
        end else if (hbl) begin
            pix_idx <= '0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_clk) begin
            $display("timeout: the run did not end within %0d clk", timeout_clk);
            abort_run();
        end
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        obj_cs     = 1'b0;
        cpu_wrn    = 1'b1;
        cpu_addr   = '0;
        cpu_dout   = '0;
        vpos       = '0;
        hbl        = 1'b1;
        pxl_cen    = 1'b0;
        cur_valid  = 1'b0;
        next_valid = 1'b0;
        cur_vpos   = '0;
        drawn_vpos = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 512; i++) cpu_write(ram_addr_t'(i), 8'h00);  // long first blank

        run_lines(4);                                   // empty table
        queue_obj(0, 8'h40, 8'h80, 8'h35, 8'h12, 8'h20);
        queue_obj(1, 8'h40, 8'h00, 8'h35, 8'h12, 8'h60);  // disabled twin
        cur_vpos = 8'd172;
        run_lines(24);
        queue_byte(9'd1, 8'h90);                        // 32 rows tall
        cur_vpos = 8'd158;
        run_lines(37);
        queue_obj(2, 8'h40, 8'h80, 8'h7a, 8'h33, 8'h28);  // overlaps object 0
        cur_vpos = 8'd178;
        run_lines(5);
        queue_byte(9'd11, 8'h88);                       // hflip on object 2
        run_lines(5);

        // forty objects on lines 100 to 115, some off the right edge
        for (int i = 0; i < 40; i++)
            queue_obj(i, 8'd140, 8'h80 | ((i % 3 == 0) ? 8'h08 : 8'h00),
                      8'(i * 16 + i % 7), 8'(i * 7), 8'(i * 23 + 5));
        cur_vpos = 8'd96;
        run_lines(12);

        repeat (3) begin
            queue_random_table();
            cur_vpos = 8'd230;                          // frame crosses vpos wrap
            run_lines(40);
        end
        repeat (4) @(posedge clk);

        if (n_checked == (total_lines - 1) * 256) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d pixels were checked", n_checked,
                     (total_lines - 1) * 256);
            abort_run();
        end
    end

endmodule

// ==== testbench/obj_rom_model.sv ====
/*
 * Graphics ROM model
 * Word content is a fixed hash of the address. rom_ok drops when the
 * address moves and comes back after a random wait of 1 to 4 clk.
 */

`timescale 1ns/10ps

module obj_rom_model (
    input  logic               clk,
    input  logic               rst,
    input  obj_pkg::rom_addr_t rom_addr,
    output obj_pkg::rom_word_t rom_data,
    output logic               rom_ok
);

    import obj_pkg::*;

    integer     seed = 32'h664841ca;
    rom_addr_t  last_addr;
    logic [1:0] wait_cnt;

    // two mixed halves anded, so about a third of the pixels are clear
    function automatic rom_word_t word_hash(input rom_addr_t a);
        logic [31:0] h;
        h = {14'd0, a} * 32'h9e3779b1;
        h = h ^ (h >> 15);
        h = h * 32'h85ebca6b;
        h = h ^ (h >> 13);
        return h[31:16] & h[15:0];
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            last_addr <= '0;
            wait_cnt  <= '0;
            rom_ok    <= 1'b0;
            rom_data  <= '0;
        end else if (rom_addr !== last_addr) begin
            last_addr <= rom_addr;
            rom_ok    <= 1'b0;                  // new request
            wait_cnt  <= 2'($random(seed));
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            rom_ok   <= 1'b1;
            rom_data <= word_hash(last_addr);
        end
    end

endmodule

// ==== verilog/obj_draw.sv ====
/*
 * Object drawer
 * Fetches the four ROM words of a selected object's row, unpacks the
 * bit planes into 16 pixels, applies horizontal flip and issues a line
 * buffer write for every opaque pixel that lands on screen.
 */

`timescale 1ns/10ps

module obj_draw (
    input  logic               clk,
    input  logic               rst,
    input  logic               copy,
    input  obj_pkg::obj_desc_t desc,
    output logic               copy_done,
    input  logic               pxl_cen,
    output obj_pkg::rom_addr_t rom_addr,
    input  obj_pkg::rom_word_t rom_data,
    input  logic               rom_ok,
    output obj_pkg::ln_write_t ln_wr
);

    import obj_pkg::*;

    obj_desc_t  cur;
    rom_word_t  rom_q, rom_sh;
    logic       busy, fetch, ok_dly;
    logic [1:0] word, k;          // word in row, pixel in word
    logic [3:0] idx, col;
    logic [8:0] pos;
    logic       step;

    assign rom_addr = {cur.code, cur.row, word};
    assign rom_sh   = rom_q >> k;
    assign col      = {rom_sh[12], rom_sh[8], rom_sh[4], rom_sh[0]};  // plane 3 on top
    assign idx      = {word, k};
    assign pos      = {1'b0, cur.x} + {5'd0, cur.hflip ? ~idx : idx};  // ~idx is 15-idx

    // readout owns the buffer whenever pxl_cen is up
    assign step  = busy & ~fetch & ~pxl_cen;
    assign ln_wr = '{we: step && col != 4'd0 && !pos[8], x: pos[7:0], data: {cur.pal, col}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            fetch     <= 1'b0;
            ok_dly    <= 1'b0;
            word      <= '0;
            k         <= '0;
            copy_done <= 1'b0;
        end else begin
            copy_done <= 1'b0;
            if (!busy) begin
                if (copy) begin
                    busy   <= 1'b1;
                    fetch  <= 1'b1;
                    ok_dly <= 1'b0;
                    word   <= '0;
                    k      <= '0;
                end
            end else if (fetch) begin
                ok_dly <= rom_ok;
                if (ok_dly && rom_ok) begin // two clk of rom_ok
                    fetch  <= 1'b0;
                    ok_dly <= 1'b0;
                end
            end else if (step) begin
                k <= k + 2'd1;
                if (k == 2'd3) begin
                    word <= word + 2'd1;
                    if (word == 2'd3) begin
                        busy      <= 1'b0;
                        copy_done <= 1'b1;
                    end else begin
                        fetch <= 1'b1;   // next word
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && copy) cur <= desc;
        if (fetch && ok_dly && rom_ok) rom_q <= rom_data;
    end

    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        fetch && !(ok_dly && rom_ok) |=> $stable(rom_addr));

endmodule

// ==== verilog/obj_layer.sv ====
/*
 * Object layer top
 * Scanner, drawer and double line buffer of the sprite layer,
 * with the per-line object limit and table size set here.
 */

`timescale 1ns/10ps

module obj_layer #(
    parameter int max_line_objs = 32,
    parameter int obj_count     = 102
) (
    input  logic               clk,
    input  logic               rst,
    // cpu port
    input  logic               obj_cs,
    input  logic               cpu_wrn,
    input  obj_pkg::ram_addr_t cpu_addr,
    input  obj_pkg::byte_t     cpu_dout,
    output obj_pkg::byte_t     obj_dout,
    // video timing
    input  obj_pkg::byte_t     vpos,
    input  logic               hbl,
    input  logic               pxl_cen,
    // graphics rom
    output obj_pkg::rom_addr_t rom_addr,
    input  obj_pkg::rom_word_t rom_data,
    input  logic               rom_ok,
    output obj_pkg::pxl_t      obj_pxl
);

    import obj_pkg::*;

    logic      copy, copy_done;
    obj_desc_t desc;
    ln_write_t ln_wr;

    obj_scan #(
        .max_line_objs (max_line_objs),
        .obj_count     (obj_count)
    ) i_obj_scan (
        .clk       (clk),
        .rst       (rst),
        .obj_cs    (obj_cs),
        .cpu_wrn   (cpu_wrn),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .obj_dout  (obj_dout),
        .vpos      (vpos),
        .hbl       (hbl),
        .copy      (copy),
        .desc      (desc),
        .copy_done (copy_done)
    );

    obj_draw i_obj_draw (
        .clk       (clk),
        .rst       (rst),
        .copy      (copy),
        .desc      (desc),
        .copy_done (copy_done),
        .pxl_cen   (pxl_cen),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ln_wr     (ln_wr)
    );

    obj_line_buffer i_obj_line_buffer (
        .clk     (clk),
        .rst     (rst),
        .hbl     (hbl),
        .pxl_cen (pxl_cen),
        .ln_wr   (ln_wr),
        .obj_pxl (obj_pxl)
    );

endmodule

// ==== verilog/obj_line_buffer.sv ====
/*
 * Double line buffer
 * One half takes draw writes while the other is read out on pxl_cen.
 * Halves swap on the falling edge of hblank, and the half just shown
 * is cleared one entry per clock during the blank.
 */

`timescale 1ns/10ps

module obj_line_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               hbl,
    input  logic               pxl_cen,
    input  obj_pkg::ln_write_t ln_wr,
    output obj_pkg::pxl_t      obj_pxl
);

    import obj_pkg::*;

    logic       line;         // half on screen
    logic       hbl_l, rd_dly;
    byte_t      rd_cnt;
    logic [8:0] clr_cnt;      // bit 8 set once the half is clear
    logic [8:0] buf_addr;
    pxl_t       buf_din, buf_q;
    logic       buf_we, clr_we;

    assign clr_we = hbl & ~clr_cnt[8] & ~ln_wr.we & ~pxl_cen;

    always_comb begin
        if (pxl_cen) begin
            buf_addr = {line, rd_cnt};
            buf_din  = '0;
            buf_we   = 1'b0;
        end else if (ln_wr.we) begin
            buf_addr = {~line, ln_wr.x};  // hidden half
            buf_din  = ln_wr.data;
            buf_we   = 1'b1;
        end else begin
            buf_addr = {line, clr_cnt[7:0]};
            buf_din  = '0;
            buf_we   = clr_we;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line    <= 1'b0;
            hbl_l   <= 1'b0;
            rd_dly  <= 1'b0;
            rd_cnt  <= '0;
            clr_cnt <= '0;
            obj_pxl <= '0;
        end else begin
            hbl_l  <= hbl;
            rd_dly <= pxl_cen;
            if (hbl_l && !hbl) line <= ~line;  // swap halves
            if (hbl) rd_cnt <= '0;
            else if (pxl_cen) rd_cnt <= rd_cnt + 8'd1;
            if (!hbl) clr_cnt <= '0;
            else if (clr_we) clr_cnt <= clr_cnt + 9'd1;
            if (rd_dly) obj_pxl <= buf_q;  // ram data one clk after the strobe
        end
    end

    obj_ram #(.aw(9), .dw($bits(pxl_t))) i_line_ram (
        .clk  (clk),
        .addr (buf_addr),
        .data (buf_din),
        .we   (buf_we),
        .q    (buf_q)
    );

    // drawer must yield readout cycles
    a_no_wr_on_cen: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |-> !ln_wr.we);

endmodule

// ==== verilog/obj_pkg.sv ====
/*
 * Object layer shared types
 * Vector widths for object RAM, graphics ROM and pixels, plus the
 * descriptor handed from the scanner to the drawer and the pixel
 * write handed from the drawer to the line buffer
 */

package obj_pkg;

    typedef logic [7:0]  byte_t;      // cpu data, ram byte or coordinate
    typedef logic [8:0]  ram_addr_t;  // 512 byte object table
    typedef logic [17:0] rom_addr_t;
    typedef logic [15:0] rom_word_t;  // four pixels, bit-plane order
    typedef logic [7:0]  pxl_t;       // palette : colour, colour 0 clear

    // one selected object
    typedef struct packed {
        logic [11:0] code;   // attr2 low nibble and tile id
        logic [3:0]  row;
        logic        hflip;
        logic [3:0]  pal;
        byte_t       x;
    } obj_desc_t;

    // one pixel write into the line buffer
    typedef struct packed {
        logic  we;
        byte_t x;
        pxl_t  data;
    } ln_write_t;

endpackage

// ==== verilog/obj_ram.sv ====
/*
 * Single-port synchronous RAM
 * One clock read latency, old data on a read during write.
 * Holds the object table and the double line buffer.
 */

`timescale 1ns/10ps

module obj_ram #(
    parameter int aw = 9,
    parameter int dw = 8
) (
    input  logic          clk,
    input  logic [aw-1:0] addr,
    input  logic [dw-1:0] data,
    input  logic          we,
    output logic [dw-1:0] q
);

    logic [dw-1:0] mem [0:2**aw-1];

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= data;
        q <= mem[addr];
    end

endmodule

// ==== verilog/obj_scan.sv ====
/*
 * Object scanner
 * Owns the object RAM and shares its port with the CPU. On each falling
 * edge of hblank it walks the table, tests every object against the new
 * line and hands visible ones to the drawer, up to a per-line limit.
 */

`timescale 1ns/10ps

module obj_scan #(
    parameter int max_line_objs = 32,
    parameter int obj_count     = 102
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              obj_cs,
    input  logic              cpu_wrn,
    input  obj_pkg::ram_addr_t cpu_addr,
    input  obj_pkg::byte_t    cpu_dout,
    output obj_pkg::byte_t    obj_dout,
    input  obj_pkg::byte_t    vpos,
    input  logic              hbl,
    output logic              copy,
    output obj_pkg::obj_desc_t desc,
    input  logic              copy_done
);

    import obj_pkg::*;

    localparam int iw = $clog2(obj_count + 1);
    localparam int lw = $clog2(max_line_objs + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ_Y,
        S_TEST_ATTR,
        S_READ_REST,
        S_WAIT_DRAW
    } state_t;

    state_t        state, state_nxt;
    ram_addr_t     scan, scan_nxt, ram_addr;
    logic [2:0]    off, off_nxt;      // byte within the object
    logic [iw-1:0] obj_idx;
    logic [lw-1:0] drawn;
    byte_t         y, vpos_l;
    logic [8:0]    s;
    logic          hbl_l, hbl_fall, q_valid, issue, advance;
    logic          visible, last_obj, line_full, ram_we;

    assign hbl_fall  = hbl_l & ~hbl;
    assign s         = {1'b0, vpos_l} + {1'b0, y};
    assign visible   = obj_dout[7] & (&s[7:5]) & (s[8] == obj_dout[0]) & (s[4] | obj_dout[4]);
    assign last_obj  = obj_idx == iw'(obj_count - 1);
    assign line_full = drawn == lw'(max_line_objs - 1);

    // next read position, so a byte can be issued in the cycle it is accepted
    always_comb begin
        state_nxt = state;
        scan_nxt  = scan;
        off_nxt   = off;
        advance   = 1'b0;
        case (state)
            S_READ_Y: if (q_valid) begin
                off_nxt   = 3'd1;
                state_nxt = S_TEST_ATTR;
            end
            S_TEST_ATTR: if (q_valid) begin
                if (visible) begin
                    off_nxt   = 3'd2;
                    state_nxt = S_READ_REST;
                end else if (last_obj) begin
                    state_nxt = S_IDLE;
                end else begin
                    scan_nxt  = scan + 9'd5;   // skip to next entry
                    off_nxt   = 3'd0;
                    advance   = 1'b1;
                    state_nxt = S_READ_Y;
                end
            end
            S_READ_REST: if (q_valid) begin
                if (off == 3'd4) state_nxt = S_WAIT_DRAW;
                else off_nxt = off + 3'd1;
            end
            S_WAIT_DRAW: if (copy_done) begin
                if (last_obj || line_full) begin
                    state_nxt = S_IDLE;
                end else begin
                    scan_nxt  = scan + 9'd5;
                    off_nxt   = 3'd0;
                    advance   = 1'b1;
                    state_nxt = S_READ_Y;
                end
            end
            default: state_nxt = S_IDLE;
        endcase
        if (hbl_fall) begin // new line, old work dropped
            state_nxt = S_READ_Y;
            scan_nxt  = '0;
            off_nxt   = '0;
            advance   = 1'b0;
        end
    end

    assign issue    = state_nxt inside {S_READ_Y, S_TEST_ATTR, S_READ_REST};
    assign ram_we   = obj_cs & ~cpu_wrn;
    assign ram_addr = obj_cs ? cpu_addr : scan_nxt + ram_addr_t'(off_nxt); // cpu first

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            scan    <= '0;
            off     <= '0;
            obj_idx <= '0;
            drawn   <= '0;
            hbl_l   <= 1'b0;
            q_valid <= 1'b0;
            copy    <= 1'b0;
        end else begin
            state   <= state_nxt;
            scan    <= scan_nxt;
            off     <= off_nxt;
            hbl_l   <= hbl;
            q_valid <= ~obj_cs & issue;  // stolen cycle means a repeat
            copy    <= state == S_READ_REST && q_valid && off == 3'd4 && !hbl_fall;
            if (hbl_fall) begin
                obj_idx <= '0;
                drawn   <= '0;
            end else begin
                if (advance) obj_idx <= obj_idx + 1'b1;
                if (state == S_WAIT_DRAW && copy_done) drawn <= drawn + 1'b1;
            end
        end
    end

    // object bytes as they arrive
    always_ff @(posedge clk) begin
        if (hbl_fall) vpos_l <= vpos;
        if (q_valid) begin
            case (state)
                S_READ_Y: y <= obj_dout;
                S_TEST_ATTR: begin
                    desc.row   <= s[3:0];
                    desc.hflip <= obj_dout[3];
                end
                S_READ_REST: begin
                    case (off)
                        3'd2: begin
                            desc.pal        <= obj_dout[7:4];
                            desc.code[11:8] <= obj_dout[3:0];
                        end
                        3'd3:    desc.code[7:0] <= obj_dout;  // tile id
                        default: desc.x <= obj_dout;
                    endcase
                end
                default: ;
            endcase
        end
    end

    obj_ram #(.aw(9), .dw(8)) i_obj_ram (
        .clk  (clk),
        .addr (ram_addr),
        .data (cpu_dout),
        .we   (ram_we),
        .q    (obj_dout)
    );

    // one object in flight at a time
    a_one_copy: assert property (@(posedge clk) disable iff (rst)
        copy |=> (!copy until (copy_done || hbl_fall)));

endmodule
